/* rv_isa_pkg.sv */
/*
 * RV64 instruction fields used by the memory-access stage
 * major opcodes and funct3 access-size codes, decoded straight from the word
 */
package rv_isa_pkg;

    typedef logic [31:0] inst_t;    // raw instruction word
    typedef logic [4:0]  reg_idx_t; // rs1 / rs2 / rd
    typedef logic [6:0]  opcode_t;  // inst[6:0]

    // major opcodes
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_BRANCH    = 7'b1100011; // never writes rd

    // funct3 size codes, shared by loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100; // unsigned forms, loads only
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

endpackage

/* mem_bus_pkg.sv */
/*
 * data-memory port types
 * 64-bit data word, per-byte strobe and byte offset inside a word
 */
package mem_bus_pkg;

    localparam int LANES = 8; // bytes per data word

    typedef logic [8*LANES-1:0]         xlen_t;     // alu, store, read, write-back data
    typedef logic [LANES-1:0]           strb_t;     // one bit per byte lane
    typedef logic [$clog2(LANES)-1:0]   byte_off_t; // addr[2:0]

endpackage

/* mem_stage_reg.sv */
/*
 * execute-to-memory stage register
 * holds the item while blocked, decodes load/store once at capture and
 * swaps in the write-back value for the store operand on an rs2 match
 */
`timescale 1ns/1ps

module mem_stage_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,      // capture enable, low = hold
    input  logic                   in_valid,
    input  mem_bus_pkg::xlen_t     in_pc,
    input  mem_bus_pkg::xlen_t     in_alu,
    input  mem_bus_pkg::xlen_t     in_src2,
    input  rv_isa_pkg::inst_t      in_inst,
    input  logic                   fwd_valid,
    input  rv_isa_pkg::reg_idx_t   fwd_rd,
    input  mem_bus_pkg::xlen_t     fwd_data,
    output logic                   valid,
    output mem_bus_pkg::xlen_t     pc,
    output mem_bus_pkg::xlen_t     alu,
    output rv_isa_pkg::inst_t      inst,
    output logic                   is_load,
    output logic                   is_store,
    output mem_bus_pkg::xlen_t     store_data
);

    mem_bus_pkg::xlen_t   src2_q; // store operand as captured
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::opcode_t  in_opc;

    assign in_opc = in_inst[6:0];

    // control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= 1'b0;
            is_load  <= 1'b0;
            is_store <= 1'b0;
        end else if (load) begin
            valid    <= in_valid;
            is_load  <= in_valid && (in_opc == rv_isa_pkg::OPC_LOAD);
            is_store <= in_valid && (in_opc == rv_isa_pkg::OPC_STORE);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load) begin
            pc     <= in_pc;
            alu    <= in_alu;
            inst   <= in_inst;
            src2_q <= in_src2;
        end
    end

    // ************************************************************************
    // store operand forwarding from write-back
    // ************************************************************************
    assign rs2 = inst[24:20];

    // combinational, so a write that lands while we stall is still picked up
    assign store_data = (fwd_valid && (fwd_rd == rs2) && (rs2 != '0)) ? fwd_data
                                                                       : src2_q;

endmodule

/* store_align.sv */
/*
 * store lane placement
 * moves sb/sh/sw/sd data into its byte lanes and builds the byte strobe,
 * misaligned halfword/word/doubleword give no data and no strobe
 */
`timescale 1ns/1ps

module store_align (
    input  logic [2:0]               funct3,
    input  mem_bus_pkg::byte_off_t   offset,
    input  mem_bus_pkg::xlen_t       store_data,
    output mem_bus_pkg::xlen_t       wdata,
    output mem_bus_pkg::strb_t       wstrb
);

    logic [5:0] bit_sh; // byte offset in bits

    assign bit_sh = {offset, 3'b000};

    always_comb begin
        wdata = '0;
        wstrb = '0;
        case (funct3)
            rv_isa_pkg::F3_B: begin // any lane
                wdata = mem_bus_pkg::xlen_t'(store_data[7:0]) << bit_sh;
                wstrb = mem_bus_pkg::strb_t'(8'h01) << offset;
            end
            rv_isa_pkg::F3_H: begin
                if (!offset[0]) begin // even lanes only
                    wdata = mem_bus_pkg::xlen_t'(store_data[15:0]) << bit_sh;
                    wstrb = mem_bus_pkg::strb_t'(8'h03) << offset;
                end
            end
            rv_isa_pkg::F3_W: begin
                if (offset[1:0] == 2'b00) begin // offset 0 or 4
                    wdata = mem_bus_pkg::xlen_t'(store_data[31:0]) << bit_sh;
                    wstrb = mem_bus_pkg::strb_t'(8'h0f) << offset;
                end
            end
            rv_isa_pkg::F3_D: begin
                if (offset == '0) begin
                    wdata = store_data;
                    wstrb = '1;
                end
            end
            default: ; // not a store size
        endcase
    end

endmodule

/* writeback_format.sv */
/*
 * register write-back formatting
 * load lane extraction with sign/zero extension, then the choice of
 * load data, link address or alu result, plus the rd write enable
 */
`timescale 1ns/1ps

module writeback_format (
    input  rv_isa_pkg::inst_t    inst,
    input  mem_bus_pkg::xlen_t   pc,
    input  mem_bus_pkg::xlen_t   alu,
    input  mem_bus_pkg::xlen_t   rdata,
    output logic                 wen,
    output mem_bus_pkg::xlen_t   wdata
);

    rv_isa_pkg::opcode_t  opc;
    rv_isa_pkg::reg_idx_t rd;
    logic [2:0]           funct3;
    mem_bus_pkg::xlen_t   lane;     // addressed bytes moved down to bit 0
    mem_bus_pkg::xlen_t   load_val; // extended load result

    assign opc    = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];

    assign lane = rdata >> {alu[2:0], 3'b000}; // low addr bits pick the lane

    // ************************************************************************
    // load extension
    // ************************************************************************
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_B:  load_val = {{56{lane[7]}}, lane[7:0]};
            rv_isa_pkg::F3_H:  load_val = {{48{lane[15]}}, lane[15:0]};
            rv_isa_pkg::F3_W:  load_val = {{32{lane[31]}}, lane[31:0]};
            rv_isa_pkg::F3_D:  load_val = rdata;     // aligned only
            rv_isa_pkg::F3_BU: load_val = {56'b0, lane[7:0]};
            rv_isa_pkg::F3_HU: load_val = {48'b0, lane[15:0]};
            rv_isa_pkg::F3_WU: load_val = {32'b0, lane[31:0]};
            default:           load_val = '0;
        endcase
    end

    // value select and rd enable
    always_comb begin
        case (opc)
            rv_isa_pkg::OPC_LOAD:      wdata = load_val;
            rv_isa_pkg::OPC_JAL,
            rv_isa_pkg::OPC_JALR:      wdata = pc + 64'd4; // link address
            default:                   wdata = alu;
        endcase

        case (opc)
            rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_OP,
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_OP_32,
            rv_isa_pkg::OPC_OP_IMM_32,
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC,
            rv_isa_pkg::OPC_JAL,
            rv_isa_pkg::OPC_JALR:      wen = (rd != '0); // x0 never written
            default:                   wen = 1'b0;       // store, branch, other
        endcase
    end

endmodule

/* mem_req_port.sv */
/*
 * data-memory port sequencer
 * one four-phase req/ack access per instruction: raise req, wait for ack,
 * drop req, wait for ack low, then report done until the stage advances
 */
`timescale 1ns/1ps

module mem_req_port #(
    parameter int ADDR_W = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,     // valid load/store in the stage
    input  logic                   write,
    input  logic                   advance,   // stage register moves on
    input  mem_bus_pkg::xlen_t     addr,
    input  mem_bus_pkg::xlen_t     wdata,
    input  mem_bus_pkg::strb_t     wstrb,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [ADDR_W-1:0]      mem_addr,
    output mem_bus_pkg::xlen_t     mem_wdata,
    output mem_bus_pkg::strb_t     mem_wstrb,
    input  logic                   mem_ack,
    input  mem_bus_pkg::xlen_t     mem_rdata,
    output mem_bus_pkg::xlen_t     rdata,
    output logic                   done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST, // req high, waiting for ack
        ST_RELEASE, // req dropped, waiting for ack low
        ST_DONE     // access complete, hold until advance
    } port_state_t;

    port_state_t state;

    // ************************************************************************
    // state machine
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            mem_we <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state  <= ST_REQUEST;
                        mem_we <= write;
                    end
                end
                ST_REQUEST: if (mem_ack)  state <= ST_RELEASE;
                ST_RELEASE: if (!mem_ack) state <= ST_DONE;   // phase 4 seen
                ST_DONE:    if (advance)  state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // request fields, frozen for the whole access
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            mem_addr  <= addr[ADDR_W-1:0];
            mem_wdata <= wdata;
            mem_wstrb <= wstrb;
        end
    end

    // read data sampled with ack
    always_ff @(posedge clk) begin
        if (state == ST_REQUEST && mem_ack) begin
            rdata <= mem_rdata;
        end
    end

    assign mem_req = (state == ST_REQUEST);
    assign done    = (state == ST_DONE);

endmodule

/* mem_stage.sv */
/*
 * memory-access stage of the RV64 integer pipeline
 * stage register, store/load formatting and the data-memory port, with
 * valid/ready toward execute and write-back
 */
`timescale 1ns/1ps

module mem_stage #(
    parameter int ADDR_W = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    // from execute
    input  logic                   ex_valid,
    output logic                   ex_ready,
    input  mem_bus_pkg::xlen_t     ex_pc,
    input  rv_isa_pkg::inst_t      ex_inst,
    input  mem_bus_pkg::xlen_t     ex_alu,
    input  mem_bus_pkg::xlen_t     ex_src2,
    // to write-back
    output logic                   wb_valid,
    input  logic                   wb_ready,
    output mem_bus_pkg::xlen_t     wb_pc,
    output rv_isa_pkg::inst_t      wb_inst,
    output logic                   rd_wen,
    output rv_isa_pkg::reg_idx_t   rd_idx,
    output mem_bus_pkg::xlen_t     rd_data,
    // forwarding from write-back
    input  logic                   fwd_valid,
    input  rv_isa_pkg::reg_idx_t   fwd_rd,
    input  mem_bus_pkg::xlen_t     fwd_data,
    // data memory
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [ADDR_W-1:0]      mem_addr,
    output mem_bus_pkg::xlen_t     mem_wdata,
    output mem_bus_pkg::strb_t     mem_wstrb,
    input  logic                   mem_ack,
    input  mem_bus_pkg::xlen_t     mem_rdata
);

    logic                 valid;
    logic                 is_load;
    logic                 is_store;
    mem_bus_pkg::xlen_t   pc;
    mem_bus_pkg::xlen_t   alu;
    rv_isa_pkg::inst_t    inst;
    mem_bus_pkg::xlen_t   store_data;
    mem_bus_pkg::xlen_t   st_wdata;
    mem_bus_pkg::strb_t   st_wstrb;
    mem_bus_pkg::xlen_t   ld_rdata;
    logic                 port_done;
    logic                 mem_access; // stage holds a load or store
    logic                 stall;
    logic                 out_en;     // item visible to write-back
    logic                 fmt_wen;
    mem_bus_pkg::xlen_t   fmt_wdata;

    // ************************************************************************
    // stall and handshakes
    // ************************************************************************
    assign mem_access = valid && (is_load || is_store);
    assign stall      = mem_access && !port_done;     // access still running
    assign ex_ready   = !stall && wb_ready;           // also the advance strobe
    assign out_en     = valid && !stall;

    mem_stage_reg mem_stage_reg_inst (
        .clk        (clk),
        .rst        (rst),
        .load       (ex_ready),
        .in_valid   (ex_valid),
        .in_pc      (ex_pc),
        .in_alu     (ex_alu),
        .in_src2    (ex_src2),
        .in_inst    (ex_inst),
        .fwd_valid  (fwd_valid),
        .fwd_rd     (fwd_rd),
        .fwd_data   (fwd_data),
        .valid      (valid),
        .pc         (pc),
        .alu        (alu),
        .inst       (inst),
        .is_load    (is_load),
        .is_store   (is_store),
        .store_data (store_data)
    );

    store_align store_align_inst (
        .funct3     (inst[14:12]),
        .offset     (alu[2:0]),
        .store_data (store_data),
        .wdata      (st_wdata),
        .wstrb      (st_wstrb)
    );

    mem_req_port #(
        .ADDR_W (ADDR_W)
    ) mem_req_port_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (mem_access),
        .write     (is_store),
        .advance   (ex_ready),
        .addr      (alu),        // byte address from execute
        .wdata     (st_wdata),
        .wstrb     (st_wstrb),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .rdata     (ld_rdata),
        .done      (port_done)
    );

    writeback_format writeback_format_inst (
        .inst  (inst),
        .pc    (pc),
        .alu   (alu),
        .rdata (ld_rdata),
        .wen   (fmt_wen),
        .wdata (fmt_wdata)
    );

    // write-back side, all zero while empty or blocked
    assign wb_valid = out_en;
    assign wb_pc    = out_en ? pc : '0;
    assign wb_inst  = out_en ? inst : '0;
    assign rd_wen   = out_en && fmt_wen;
    assign rd_idx   = out_en ? inst[11:7] : '0;
    assign rd_data  = out_en ? fmt_wdata : '0;

endmodule

/* tb_mem_stage.sv */
/*
 * testbench for the memory-access stage
 * random instructions from execute, a four-phase memory responder with
 * random latency, random write-back back-pressure and a queue reference model
 */
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int ADDR_W    = 32;
    localparam int NUM_ITEMS = 400;
    localparam int TIMEOUT   = 200; // cycles per wait

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   ex_valid;
    logic                   ex_ready;
    mem_bus_pkg::xlen_t     ex_pc;
    rv_isa_pkg::inst_t      ex_inst;
    mem_bus_pkg::xlen_t     ex_alu;
    mem_bus_pkg::xlen_t     ex_src2;
    logic                   wb_valid;
    logic                   wb_ready;
    mem_bus_pkg::xlen_t     wb_pc;
    rv_isa_pkg::inst_t      wb_inst;
    logic                   rd_wen;
    rv_isa_pkg::reg_idx_t   rd_idx;
    mem_bus_pkg::xlen_t     rd_data;
    logic                   fwd_valid;
    rv_isa_pkg::reg_idx_t   fwd_rd;
    mem_bus_pkg::xlen_t     fwd_data;
    logic                   mem_req;
    logic                   mem_we;
    logic [ADDR_W-1:0]      mem_addr;
    mem_bus_pkg::xlen_t     mem_wdata;
    mem_bus_pkg::strb_t     mem_wstrb;
    logic                   mem_ack;
    mem_bus_pkg::xlen_t     mem_rdata;

    // reference model, one entry per item accepted from execute
    mem_bus_pkg::xlen_t     q_pc[$];
    rv_isa_pkg::inst_t      q_inst[$];
    mem_bus_pkg::xlen_t     q_alu[$];
    mem_bus_pkg::xlen_t     q_src2[$];

    rv_isa_pkg::opcode_t opcodes[11] = '{
        rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_OP,
        rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_32, rv_isa_pkg::OPC_OP_IMM_32,
        rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_JAL,
        rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_BRANCH
    };

    int                   errors    = 0;
    int                   items     = 0;
    int                   reqs      = 0;
    int                   req_count = 0;  // requests seen for the head item
    int                   ack_wait  = -1; // responder countdown, -1 idle
    logic                 go        = 1'b0;
    logic                 taken     = 1'b0; // ex handshake seen
    logic                 timed_out = 1'b0;
    logic                 prev_req, prev_ack, prev_fwd_valid, hold;
    rv_isa_pkg::reg_idx_t prev_fwd_rd;
    mem_bus_pkg::xlen_t   prev_fwd_data, cap_rdata;
    mem_bus_pkg::xlen_t   h_pc, h_data;
    rv_isa_pkg::inst_t    h_inst;
    logic                 h_wen;
    rv_isa_pkg::reg_idx_t h_idx;

    mem_stage #(
        .ADDR_W (ADDR_W)
    ) mem_stage_inst (
        .clk       (clk),       .rst       (rst),
        .ex_valid  (ex_valid),  .ex_ready  (ex_ready),
        .ex_pc     (ex_pc),     .ex_inst   (ex_inst),
        .ex_alu    (ex_alu),    .ex_src2   (ex_src2),
        .wb_valid  (wb_valid),  .wb_ready  (wb_ready),
        .wb_pc     (wb_pc),     .wb_inst   (wb_inst),
        .rd_wen    (rd_wen),    .rd_idx    (rd_idx),
        .rd_data   (rd_data),   .fwd_valid (fwd_valid),
        .fwd_rd    (fwd_rd),    .fwd_data  (fwd_data),
        .mem_req   (mem_req),   .mem_we    (mem_we),
        .mem_addr  (mem_addr),  .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb), .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    always #2 clk = ~clk; // 4 ns period

    // ************************************************************************
    // model rules
    // ************************************************************************
    function automatic logic writes_rd(rv_isa_pkg::inst_t i);
        if (i[11:7] == 5'd0) return 1'b0; // x0
        // stimulus only uses the eleven decoded opcodes
        return (i[6:0] != rv_isa_pkg::OPC_STORE) && (i[6:0] != rv_isa_pkg::OPC_BRANCH);
    endfunction

    function automatic mem_bus_pkg::xlen_t extend_load(logic [2:0] f3, int off,
                                                       mem_bus_pkg::xlen_t rdata);
        mem_bus_pkg::xlen_t v;
        int n;
        int k;
        n = 1 << f3[1:0]; // bytes in the access
        v = '0;
        for (k = 0; k < n; k++) v[k*8 +: 8] = rdata[(off + k)*8 +: 8];
        if (!f3[2]) begin // signed forms
            for (k = n*8; k < 64; k++) v[k] = v[n*8 - 1];
        end
        return v;
    endfunction

    task automatic lane_store(input logic [2:0] f3, input int off,
                              input mem_bus_pkg::xlen_t data,
                              output mem_bus_pkg::xlen_t wd, output mem_bus_pkg::strb_t ws);
        int n;
        int k;
        n  = 1 << f3[1:0];
        wd = '0;
        ws = '0;
        if (off % n == 0) begin // natural alignment only
            for (k = 0; k < n; k++) begin
                wd[(off + k)*8 +: 8] = data[k*8 +: 8];
                ws[off + k]          = 1'b1;
            end
        end
    endtask

    task automatic flag_mismatch(string name, mem_bus_pkg::xlen_t got,
                                 mem_bus_pkg::xlen_t want);
        errors++;
        $display("error %s at %0t: got %h, expected %h", name, $time, got, want);
    endtask

    // ************************************************************************
    // checks at the memory port and at write-back
    // ************************************************************************
    task automatic check_request();
        rv_isa_pkg::inst_t  i;
        mem_bus_pkg::xlen_t data, wd;
        mem_bus_pkg::strb_t ws;
        if (q_inst.size() == 0) begin
            errors++;
            $display("memory request raised at %0t with the stage empty", $time);
        end else begin
            i = q_inst[0];
            reqs++;
            req_count++;
            if (prev_ack) begin // phase 4 not finished
                errors++;
                $display("mem_req rose at %0t while mem_ack was still high", $time);
            end
            if (mem_addr !== q_alu[0][ADDR_W-1:0])
                flag_mismatch("mem_addr", mem_addr, q_alu[0][ADDR_W-1:0]);
            if (i[6:0] == rv_isa_pkg::OPC_STORE) begin
                // fields were captured one edge back, with the fwd inputs of then
                if (prev_fwd_valid && (prev_fwd_rd == i[24:20]) && (i[24:20] != 5'd0))
                    data = prev_fwd_data;
                else
                    data = q_src2[0];
                lane_store(i[14:12], q_alu[0][2:0], data, wd, ws);
                if (mem_we !== 1'b1) flag_mismatch("mem_we", mem_we, 1);
                if (mem_wdata !== wd) flag_mismatch("mem_wdata", mem_wdata, wd);
                if (mem_wstrb !== ws) flag_mismatch("mem_wstrb", mem_wstrb, ws);
            end else if (mem_we !== 1'b0) begin
                flag_mismatch("mem_we", mem_we, 0);
            end
        end
    endtask

    task automatic check_writeback();
        rv_isa_pkg::inst_t  i;
        mem_bus_pkg::xlen_t d;
        int                 want_reqs;
        if (q_inst.size() == 0) begin
            errors++;
            $display("write-back item at %0t with no item sent", $time);
        end else begin
            i = q_inst[0];
            want_reqs = 0;
            if (i[6:0] == rv_isa_pkg::OPC_LOAD) begin
                d = extend_load(i[14:12], q_alu[0][2:0], cap_rdata);
                want_reqs = 1;
            end else if (i[6:0] == rv_isa_pkg::OPC_JAL || i[6:0] == rv_isa_pkg::OPC_JALR) begin
                d = q_pc[0] + 64'd4; // link
            end else begin
                d = q_alu[0];
                if (i[6:0] == rv_isa_pkg::OPC_STORE) want_reqs = 1;
            end
            if (wb_pc !== q_pc[0]) flag_mismatch("wb_pc", wb_pc, q_pc[0]);
            if (wb_inst !== i) flag_mismatch("wb_inst", wb_inst, i);
            if (rd_idx !== i[11:7]) flag_mismatch("rd_idx", rd_idx, i[11:7]);
            if (rd_wen !== writes_rd(i)) flag_mismatch("rd_wen", rd_wen, writes_rd(i));
            if (rd_data !== d) flag_mismatch("rd_data", rd_data, d);
            if (req_count != want_reqs) begin
                errors++;
                $display("item with pc %h made %0d memory requests", q_pc[0], req_count);
            end
            req_count = 0;
            items++;
            void'(q_pc.pop_front());
            void'(q_inst.pop_front());
            void'(q_alu.pop_front());
            void'(q_src2.pop_front());
        end
    endtask

    // pre-edge values, inputs only move on the falling edge
    always @(posedge clk) begin
        if (!rst) begin
            if (mem_req && !prev_req) check_request();
            if (mem_req && mem_ack) cap_rdata = mem_rdata; // what the port latches
            // empty or blocked stage shows nothing to write-back
            if (!wb_valid && (wb_pc !== '0 || wb_inst !== '0 || rd_wen !== 1'b0 ||
                              rd_idx !== '0 || rd_data !== '0)) begin
                errors++;
                $display("write-back fields not zero at %0t while wb_valid is low", $time);
            end
            if (q_inst.size() == 0 && ex_ready !== wb_ready)
                flag_mismatch("ex_ready", ex_ready, wb_ready); // empty stage never blocks
            if (hold) begin // blocked output must not move
                if (wb_valid !== 1'b1) flag_mismatch("wb_valid (held)", wb_valid, 1);
                if (wb_pc !== h_pc) flag_mismatch("wb_pc (held)", wb_pc, h_pc);
                if (wb_inst !== h_inst) flag_mismatch("wb_inst (held)", wb_inst, h_inst);
                if (rd_wen !== h_wen) flag_mismatch("rd_wen (held)", rd_wen, h_wen);
                if (rd_idx !== h_idx) flag_mismatch("rd_idx (held)", rd_idx, h_idx);
                if (rd_data !== h_data) flag_mismatch("rd_data (held)", rd_data, h_data);
            end
            hold   = wb_valid && !wb_ready;
            h_pc   = wb_pc;
            h_inst = wb_inst;
            h_wen  = rd_wen;
            h_idx  = rd_idx;
            h_data = rd_data;
            if (wb_valid && wb_ready) check_writeback();
            if (ex_valid && ex_ready) begin
                q_pc.push_back(ex_pc);
                q_inst.push_back(ex_inst);
                q_alu.push_back(ex_alu);
                q_src2.push_back(ex_src2);
                taken = 1'b1;
            end
        end
        prev_req       = mem_req;
        prev_ack       = mem_ack;
        prev_fwd_valid = fwd_valid;
        prev_fwd_rd    = fwd_rd;
        prev_fwd_data  = fwd_data;
    end

    // ************************************************************************
    // back-pressure, forwarding and memory responder
    // ************************************************************************
    always @(negedge clk) begin
        if (go) begin
            wb_ready  = ($urandom_range(0, 3) != 0); // low about one cycle in four
            fwd_valid = $urandom_range(0, 1);
            fwd_rd    = $urandom_range(0, 3);        // same small range as rs2
            fwd_data  = {$urandom, $urandom};
            if (mem_ack) begin
                if (!mem_req) mem_ack = 1'b0;        // phase 4
            end else if (mem_req) begin
                if (ack_wait < 0) ack_wait = $urandom_range(0, 5);
                if (ack_wait == 0) begin
                    mem_ack   = 1'b1;
                    mem_rdata = {$urandom, $urandom};
                end
                ack_wait--;
            end
        end
    end

    // one item from execute, called on a falling edge
    task automatic send_item();
        int                  idle, waited, size, off;
        rv_isa_pkg::opcode_t opc;
        rv_isa_pkg::inst_t   i;
        mem_bus_pkg::xlen_t  a;
        idle = $urandom_range(0, 2);
        repeat (idle) @(negedge clk);
        opc      = opcodes[$urandom_range(0, 10)];
        i        = $urandom;
        i[6:0]   = opc;
        i[11:7]  = $urandom_range(0, 7); // rd, x0 now and then
        i[24:20] = $urandom_range(0, 3); // rs2, often hits fwd_rd
        if (opc == rv_isa_pkg::OPC_LOAD) i[14:12] = $urandom_range(0, 6);
        if (opc == rv_isa_pkg::OPC_STORE) i[14:12] = $urandom_range(0, 3);
        a    = {$urandom, $urandom};
        size = 1 << i[13:12];
        off  = $urandom_range(0, 7);
        if (opc == rv_isa_pkg::OPC_LOAD || opc == rv_isa_pkg::OPC_STORE)
            a[2:0] = off - (off % size); // aligned offset
        ex_pc    = {$urandom, $urandom} & ~64'h3;
        ex_inst  = i;
        ex_alu   = a;
        ex_src2  = {$urandom, $urandom};
        ex_valid = 1'b1;
        taken    = 1'b0;
        waited   = 0;
        while (!taken && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!taken) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: execute item with pc %h never accepted", ex_pc);
        end
        ex_valid = 1'b0;
        taken    = 1'b0;
    endtask

    initial begin
        int n;
        int waited;
        void'($urandom(32'hefa4_7249));
        rst       = 1'b1;
        ex_valid  = 1'b0;
        ex_pc     = '0;
        ex_inst   = '0;
        ex_alu    = '0;
        ex_src2   = '0;
        wb_ready  = 1'b1;
        fwd_valid = 1'b0;
        fwd_rd    = '0;
        fwd_data  = '0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        #1;
        if (wb_valid !== 1'b0) flag_mismatch("wb_valid", wb_valid, 0);
        if (mem_req !== 1'b0) flag_mismatch("mem_req", mem_req, 0);
        if (rd_wen !== 1'b0) flag_mismatch("rd_wen", rd_wen, 0);
        if (ex_ready !== wb_ready) flag_mismatch("ex_ready", ex_ready, wb_ready);
        go = 1'b1;

        @(negedge clk);
        n = 0;
        while (n < NUM_ITEMS && !timed_out) begin
            send_item();
            n++;
        end

        // drain what is still in the stage
        waited = 0;
        while (q_inst.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (q_inst.size() != 0) begin
            errors++;
            $display("timeout: %0d items never reached write-back", q_inst.size());
        end

        $display("items %0d, memory requests %0d, errors %0d", items, reqs, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
rv_isa_pkg.sv
mem_bus_pkg.sv
mem_stage_reg.sv
store_align.sv
writeback_format.sv
mem_req_port.sv
mem_stage.sv
tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - rv_isa_pkg.sv
  - mem_bus_pkg.sv
  - mem_stage_reg.sv
  - store_align.sv
  - writeback_format.sv
  - mem_req_port.sv
  - mem_stage.sv
  - target: simulation
    files:
      - tb_mem_stage.sv
